// ==== rv_front_end.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_fetch_stage.sv
verilog/rv_op_table.sv
verilog/rv_decode_stage.sv
verilog/rv_front_end.sv
verif/rv_tb_clock.sv
verif/rv_front_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the RV32I front end testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f rv_front_end.f --top-module rv_front_end_tb

./obj_dir/Vrv_front_end_tb 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "Simulation reported a failure."
	exit 1
fi
grep -q "sim passed" sim.log

// ==== verif/rv_front_end_tb.sv ====
/*
 Testbench of the RV32I front end.
 Drives directed and LFSR-generated words, predicts every decode record
 with a reference model and checks each one in the cycle it is due.
*/
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_front_end_tb
	import rv_pkg::*;
();

	localparam int          random_words = 400;
	localparam int          wait_limit = 1000;
	localparam logic [31:0] lfsr_seed = 32'h3df78d85;
	localparam int          directed_count = 25;

	// Fifteen legal words of every class, then ten undefined encodings.
	localparam logic [31:0] directed_words [directed_count] = '{
		32'hfff00093, 32'h800002b7, 32'h00001197, 32'hffdff0ef, 32'h00008067,
		32'hfe208ce3, 32'h0020f463, 32'hff412303, 32'h00414283, 32'hfe712e23,
		32'h41f0d093, 32'h00311113, 32'h0020b1b3, 32'h402081b3, 32'h00000033,
		32'h00000000, 32'hffffffff, 32'h0000000f, 32'h00000073, 32'h00002063,
		32'h00003003, 32'h00004023, 32'h40001033, 32'h02001013, 32'h00001067
	};

	typedef struct packed {
		rv_decode_data_t record;
		logic            fault;
		logic [31:0]     due_cycle;
	} expected_t;

	logic                clock;
	logic                reset;
	logic                strobe;
	rv_inst_t            instruction;
	rv_decode_data_t     data;
	logic                fault;
	expected_t           expected_q[$];
	expected_t           head;
	logic [31:0]         cycle;
	logic [31:0]         lfsr_state;
	logic [`RV_XLEN-1:0] next_pc;

	rv_tb_clock clock0 (
		.o_clock (clock),
		.o_reset (reset)
	);

	rv_front_end dut0 (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_strobe      (strobe),
		.i_instruction (instruction),
		.o_data        (data),
		.o_fault       (fault)
	);

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1, "Stopped at the first failing check.");
	endtask

	// ========================================================================
	// Stimulus sources
	// ========================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// The LFSR advances once for every bit taken. The newest bit lands at bit 0.
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int n = 0; n < count; n++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [6:0] legal_opcode(input logic [3:0] index);
		case (index)
			4'd0:    return opc_lui;
			4'd1:    return opc_auipc;
			4'd2:    return opc_jal;
			4'd3:    return opc_jalr;
			4'd4:    return opc_branch;
			4'd5:    return opc_load;
			4'd6:    return opc_store;
			4'd7:    return opc_op_imm;
			default: return opc_op;
		endcase
	endfunction

	// Most words are bent into a legal form while the rest stay raw.
	function automatic logic [31:0] make_word();
		logic [31:0] w;
		logic [3:0]  kind;
		logic [2:0]  f3;
		w = random_bits(32);
		kind = 4'(random_bits(4));
		f3 = w[14:12];
		case (kind)
			4'd0: w[6:0] = opc_lui;
			4'd1: w[6:0] = opc_auipc;
			4'd2: w[6:0] = opc_jal;
			4'd3: begin
				w[6:0] = opc_jalr;
				w[14:12] = 3'b000;
			end
			4'd4: begin
				w[6:0] = opc_branch;
				if (f3[2:1] == 2'b01)
					w[14] = 1'b1;
			end
			4'd5: begin
				w[6:0] = opc_load;
				if (f3 inside {3'b011, 3'b110, 3'b111})
					w[14:12] = 3'b010;
			end
			4'd6: begin
				w[6:0] = opc_store;
				if (f3[2] || f3[1:0] == 2'b11)
					w[14:12] = {2'b00, f3[0]};
			end
			4'd7: begin
				w[6:0] = opc_op_imm;
				// Above the shamt only the arithmetic shift bit may be set.
				if (f3 == 3'b001)
					w[31:25] = 7'b0;
				else if (f3 == 3'b101)
					w[31:25] = {1'b0, w[30], 5'b0};
			end
			4'd8: begin
				w[6:0] = opc_op;
				if (w[30] && (f3 == 3'b000 || f3 == 3'b101))
					w[31:25] = 7'b0100000;
				else
					w[31:25] = 7'b0;
			end
			4'd9, 4'd10: w[6:0] = legal_opcode(4'(random_bits(4)));
			default: ;
		endcase
		return w;
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================

	// Expected decode of one word, taken from the RV32I encoding rules.
	function automatic rv_decode_data_t reference_decode(input logic [31:0] w,
		input logic [`RV_XLEN-1:0] pc, output logic is_illegal);
		rv_decode_data_t r;
		logic [2:0]      f3;
		logic [6:0]      f7;
		logic            use_rs1;
		logic            use_rs2;
		logic            use_rd;
		logic [31:0]     imm_i;
		r = '0;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		is_illegal = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd = 1'b0;
		case (w[6:0])
			opc_lui, opc_auipc: begin
				use_rd = 1'b1;
				r.imm = {w[31:12], 12'b0};
				r.arithmetic = 1'b1;
				r.alu_operand1 = (w[6:0] == opc_lui) ? opnd_zero : opnd_pc;
				r.alu_operand2 = opnd_imm;
			end
			opc_jal: begin
				use_rd = 1'b1;
				r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				r.jump = 1'b1;
				r.alu_operand1 = opnd_pc;
				r.alu_operand2 = opnd_imm;
			end
			opc_jalr: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				r.imm = imm_i;
				r.jump = 1'b1;
				r.alu_operand1 = opnd_rs1;
				r.alu_operand2 = opnd_imm;
				is_illegal = (f3 != 3'b000);
			end
			opc_branch: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				r.compare = 1'b1;
				r.jump_conditional = 1'b1;
				r.alu_operand1 = opnd_rs1;
				r.alu_operand2 = opnd_rs2;
				case (f3)
					3'b000, 3'b001: r.alu_operation = alu_sub;
					3'b100, 3'b101: r.alu_operation = alu_slt;
					3'b110, 3'b111: r.alu_operation = alu_sltu;
					default:        is_illegal = 1'b1;
				endcase
			end
			opc_load, opc_store: begin
				use_rs1 = 1'b1;
				use_rs2 = (w[6:0] == opc_store);
				use_rd = (w[6:0] == opc_load);
				r.imm = use_rd ? imm_i : {{20{w[31]}}, w[31:25], w[11:7]};
				r.memory_read = use_rd;
				r.memory_write = use_rs2;
				r.alu_operand1 = opnd_rs1;
				r.alu_operand2 = opnd_imm;
				// Loads sign-extend unless bit 2 of funct3 asks for zero extension.
				r.memory_signed = use_rd && !f3[2];
				case (f3[1:0])
					2'b00:   r.memory_width = mem_byte;
					2'b01:   r.memory_width = mem_half;
					2'b10:   r.memory_width = mem_word;
					default: is_illegal = 1'b1;
				endcase
				if (f3[2] && (use_rs2 || f3[1]))
					is_illegal = 1'b1;
			end
			opc_op_imm, opc_op: begin
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				use_rs2 = (w[6:0] == opc_op);
				r.alu_operand1 = opnd_rs1;
				r.alu_operand2 = use_rs2 ? opnd_rs2 : opnd_imm;
				r.imm = use_rs2 ? 32'd0 : imm_i;
				case (f3)
					3'b000:  r.alu_operation = alu_add;
					3'b001:  r.alu_operation = alu_sll;
					3'b010:  r.alu_operation = alu_slt;
					3'b011:  r.alu_operation = alu_sltu;
					3'b100:  r.alu_operation = alu_xor;
					3'b101:  r.alu_operation = alu_srl;
					3'b110:  r.alu_operation = alu_or;
					default: r.alu_operation = alu_and;
				endcase
				// Funct7 picks sub and sra. Any other nonzero funct7 is undefined here.
				if (f3 == 3'b001 || f3 == 3'b101 || use_rs2) begin
					if (f7 == 7'b0100000 && (f3 == 3'b101 || (f3 == 3'b000 && use_rs2)))
						r.alu_operation = (f3 == 3'b000) ? alu_sub : alu_sra;
					else if (f7 != 7'b0)
						is_illegal = 1'b1;
				end
				if (!use_rs2 && (f3 == 3'b001 || f3 == 3'b101))
					r.imm = {27'b0, w[24:20]};
				r.shift = r.alu_operation inside {alu_sll, alu_srl, alu_sra};
				r.compare = r.alu_operation inside {alu_slt, alu_sltu};
				r.arithmetic = !(r.shift || r.compare);
			end
			default: is_illegal = 1'b1;
		endcase

		// An undefined word keeps its register fields and decodes to nothing else.
		if (is_illegal)
			r = '0;
		r.strobe = 1'b1;
		r.pc = pc;
		r.inst_rs1 = use_rs1 ? w[19:15] : 5'd0;
		r.inst_rs2 = use_rs2 ? w[24:20] : 5'd0;
		r.inst_rd = use_rd ? w[11:7] : 5'd0;
		r.have_rs = {r.inst_rs2 != 5'd0, r.inst_rs1 != 5'd0};
		return r;
	endfunction

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic compare_decode(input rv_decode_data_t got, input rv_decode_data_t exp);
		string field;
		field = "";
		if (got.pc !== exp.pc)
			field = "pc";
		else if ({got.have_rs, got.inst_rs1, got.inst_rs2, got.inst_rd}
			!== {exp.have_rs, exp.inst_rs1, exp.inst_rs2, exp.inst_rd})
			field = "register fields";
		else if (got.imm !== exp.imm)
			field = "immediate";
		else if ({got.arithmetic, got.shift, got.compare, got.jump, got.jump_conditional}
			!== {exp.arithmetic, exp.shift, exp.compare, exp.jump, exp.jump_conditional})
			field = "class flags";
		else if ({got.alu_operation, got.alu_operand1, got.alu_operand2}
			!== {exp.alu_operation, exp.alu_operand1, exp.alu_operand2})
			field = "ALU controls";
		else if ({got.memory_read, got.memory_write, got.memory_width, got.memory_signed}
			!== {exp.memory_read, exp.memory_write, exp.memory_width, exp.memory_signed})
			field = "memory controls";
		else if (got !== exp)
			field = "strobe";
		if (field != "")
			stop_on_failure($sformatf("[ERROR] %0t: %s wrong for pc %h, got %h, expected %h",
				$time, field, exp.pc, got, exp));
	endtask

	task automatic compare_fault(input logic got, input logic exp, input logic [31:0] pc);
		if (got !== exp)
			stop_on_failure($sformatf("[ERROR] %0t: fault is %b for pc %h, expected %b",
				$time, got, pc, exp));
	endtask

	always @(posedge clock) begin
		if (reset)
			cycle <= '0;
		else
			cycle <= cycle + 32'd1;
	end

	// Outputs settle after the rising edge, so they are checked on the falling edge.
	always @(negedge clock) begin
		if (!reset) begin
			if (data.strobe) begin
				if (expected_q.size() == 0)
					stop_on_failure($sformatf("[ERROR] %0t: output strobe with no word outstanding",
						$time));
				else begin
					head = expected_q.pop_front();
					if (head.due_cycle != cycle)
						stop_on_failure($sformatf("[ERROR] %0t: pc %h came in cycle %0d, due in %0d",
							$time, head.record.pc, cycle, head.due_cycle));
					else begin
						compare_decode(data, head.record);
						compare_fault(fault, head.fault, head.record.pc);
					end
				end
			end
			else if (fault)
				stop_on_failure($sformatf("[ERROR] %0t: fault raised without a strobe", $time));
			else if (expected_q.size() != 0 && expected_q[0].due_cycle <= cycle)
				stop_on_failure($sformatf("[ERROR] %0t: no output strobe for pc %h",
					$time, expected_q[0].record.pc));
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic send_word(input logic [31:0] word);
		expected_t item;
		logic      illegal;
		@(posedge clock);
		#1;
		strobe = 1'b1;
		instruction = word;
		item.record = reference_decode(word, next_pc, illegal);
		item.fault = illegal;
		item.due_cycle = cycle + 32'd2;
		expected_q.push_back(item);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic send_idle();
		@(posedge clock);
		#1;
		strobe = 1'b0;
	endtask

	task automatic wait_for_reset_release();
		int n;
		n = 0;
		while (reset !== 1'b0 && n < wait_limit) begin
			@(posedge clock);
			n++;
		end
		if (reset !== 1'b0)
			stop_on_failure("Reset was never released.");
	endtask

	initial begin
		int n;
		strobe = 1'b0;
		instruction = '0;
		lfsr_state = lfsr_seed;
		next_pc = `RV_RESET_PC;

		wait_for_reset_release();
		#1;
		compare_decode(data, '0);
		compare_fault(fault, 1'b0, '0);

		repeat (3) send_idle();
		for (int k = 0; k < directed_count; k++)
			send_word(directed_words[k]);
		repeat (3) send_idle();
		for (int k = 0; k < random_words; k++) begin
			send_word(make_word());
			if (random_bits(2) == 32'd0)
				send_idle();
		end
		send_idle();

		n = 0;
		while (expected_q.size() != 0 && n < wait_limit) begin
			@(posedge clock);
			n++;
		end
		repeat (4) @(posedge clock);
		if (expected_q.size() != 0)
			stop_on_failure($sformatf("Timed out with %0d decode results still missing.",
				expected_q.size()));
		else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== verif/rv_tb_clock.sv ====
/*
 Testbench clock and reset.
 Free-running 4 ns clock and a synchronous reset held for three cycles.
*/
`timescale 1ns/1ps

module rv_tb_clock (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #2 o_clock = ~o_clock;
	end

	// Reset drops a nanosecond after the third rising edge.
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		#1 o_reset = 1'b0;
	end

endmodule

// ==== verilog/rv_front_end.sv ====
/*
 RV32I instruction front end.
 Fetch numbers the incoming words, decode turns them into operation
 records two cycles after the strobe.
*/
`timescale 1ns/1ps

module rv_front_end
	import rv_pkg::*;
(
	input  logic            i_clock,
	input  logic            i_reset,
	input  logic            i_strobe,
	input  rv_inst_t        i_instruction,
	output rv_decode_data_t o_data,
	output logic            o_fault
);

	// Record passed from the fetch register to decode.
	rv_fetch_data_t fetch_data;

	rv_fetch_stage fetch0 (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_strobe      (i_strobe),
		.i_instruction (i_instruction),
		.o_data        (fetch_data)
	);

	rv_decode_stage decode0 (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_data  (fetch_data),
		.o_data  (o_data),
		.o_fault (o_fault)
	);

endmodule

// ==== verilog/rv_decode_stage.sv ====
/*
 RV32I decode stage.
 Registers the fetched register fields, builds the immediate of the
 word's format and the decoded operation, and flags illegal words.
*/
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decode_stage
	import rv_pkg::*;
(
	input  logic            i_clock,
	input  logic            i_reset,
	input  rv_fetch_data_t  i_data,
	output rv_decode_data_t o_data,
	output logic            o_fault
);

	rv_inst_t            inst;
	rv_op_info_t         info;
	logic [`RV_XLEN-1:0] imm_i;
	logic [`RV_XLEN-1:0] imm_s;
	logic [`RV_XLEN-1:0] imm_b;
	logic [`RV_XLEN-1:0] imm_u;
	logic [`RV_XLEN-1:0] imm_j;
	logic [`RV_XLEN-1:0] imm_shamt;
	logic [`RV_XLEN-1:0] imm;

	assign inst = i_data.instruction;

	rv_op_table op_table0 (
		.i_instruction (inst),
		.o_info        (info)
	);

	// ========================================================================
	// Immediates, one per format view
	// ========================================================================

	assign imm_i = {{(`RV_XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{(`RV_XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	assign imm_b = {{(`RV_XLEN-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
		inst.b.imm_4_1, 1'b0};
	assign imm_u = {inst.u.imm_31_12, 12'b0};
	assign imm_j = {{(`RV_XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
		inst.j.imm_10_1, 1'b0};

	// The shift amount sits in the low bits of the I immediate.
	assign imm_shamt = {{(`RV_XLEN-5){1'b0}}, inst.i.imm_11_0[4:0]};

	always_comb begin
		case (info.format)
			fmt_i:   imm = imm_i;
			fmt_s:   imm = imm_s;
			fmt_b:   imm = imm_b;
			fmt_u:   imm = imm_u;
			fmt_j:   imm = imm_j;
			// Only the immediate shifts among the R words have an operand here.
			fmt_r:   imm = (info.shift && inst.r.opcode == opc_op_imm) ? imm_shamt : '0;
			default: imm = '0;
		endcase
	end

	// ========================================================================
	// Output register
	// ========================================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data <= '0;
			o_fault <= 1'b0;
		end
		else begin
			o_data.strobe <= i_data.strobe;
			o_data.pc <= i_data.pc;
			o_data.have_rs <= {i_data.inst_rs2 != '0, i_data.inst_rs1 != '0};
			o_data.inst_rs1 <= i_data.inst_rs1;
			o_data.inst_rs2 <= i_data.inst_rs2;
			o_data.inst_rd <= i_data.inst_rd;
			o_data.imm <= imm;

			o_data.arithmetic <= info.arithmetic;
			o_data.shift <= info.shift;
			o_data.compare <= info.compare;
			o_data.jump <= info.jump;
			o_data.jump_conditional <= info.jump_conditional;

			o_data.alu_operation <= info.alu_operation;
			o_data.alu_operand1 <= info.alu_operand1;
			o_data.alu_operand2 <= info.alu_operand2;

			o_data.memory_read <= info.memory_read;
			o_data.memory_write <= info.memory_write;
			o_data.memory_width <= info.memory_width;
			o_data.memory_signed <= info.memory_signed;

			// Fault pulses only for a real item.
			o_fault <= i_data.strobe & info.illegal;
		end
	end

endmodule

// ==== verilog/rv_op_table.sv ====
/*
 RV32I operation table.
 Combinational lookup over opcode, funct3 and funct7 that gives the
 format, class flags, ALU setup, memory controls and legality.
*/
`timescale 1ns/1ps

module rv_op_table
	import rv_pkg::*;
(
	input  rv_inst_t    i_instruction,
	output rv_op_info_t o_info
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = i_instruction.r.opcode;
	assign funct3 = i_instruction.r.funct3;
	assign funct7 = i_instruction.r.funct7;

	// Shared by OP and OP-IMM; alt selects sub and sra.
	function automatic rv_alu_op_t alu_for_funct3(input logic [2:0] f3, input logic alt);
		rv_alu_op_t op;
		case (f3)
			3'b000:  op = alt ? alu_sub : alu_add;
			3'b001:  op = alu_sll;
			3'b010:  op = alu_slt;
			3'b011:  op = alu_sltu;
			3'b100:  op = alu_xor;
			3'b101:  op = alt ? alu_sra : alu_srl;
			3'b110:  op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		o_info = '0;
		o_info.alu_operation = alu_add;
		case (opcode)
			opc_lui: begin
				o_info.format = fmt_u;
				o_info.arithmetic = 1'b1;
				o_info.alu_operand1 = opnd_zero;
				o_info.alu_operand2 = opnd_imm;
			end
			opc_auipc, opc_jal: begin
				o_info.format = (opcode == opc_jal) ? fmt_j : fmt_u;
				o_info.arithmetic = (opcode == opc_auipc);
				o_info.jump = (opcode == opc_jal);
				o_info.alu_operand1 = opnd_pc;
				o_info.alu_operand2 = opnd_imm;
			end
			opc_jalr: begin
				o_info.format = fmt_i;
				o_info.jump = 1'b1;
				o_info.alu_operand1 = opnd_rs1;
				o_info.alu_operand2 = opnd_imm;
				o_info.illegal = (funct3 != 3'b000);
			end
			opc_branch: begin
				o_info.format = fmt_b;
				o_info.compare = 1'b1;
				o_info.jump_conditional = 1'b1;
				o_info.alu_operand1 = opnd_rs1;
				o_info.alu_operand2 = opnd_rs2;
				// The beq and bne compares subtract while the ordered ones use slt or sltu.
				if (!funct3[2])
					o_info.alu_operation = alu_sub;
				else
					o_info.alu_operation = funct3[1] ? alu_sltu : alu_slt;
				o_info.illegal = (funct3[2:1] == 2'b01);
			end
			opc_load, opc_store: begin
				o_info.format = (opcode == opc_load) ? fmt_i : fmt_s;
				o_info.memory_read = (opcode == opc_load);
				o_info.memory_write = (opcode == opc_store);
				o_info.memory_width = rv_mem_width_t'(funct3[1:0]);
				o_info.memory_signed = (opcode == opc_load) && !funct3[2];
				o_info.alu_operand1 = opnd_rs1;
				o_info.alu_operand2 = opnd_imm;
				if (opcode == opc_load)
					o_info.illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
				else
					o_info.illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			opc_op_imm: begin
				o_info.alu_operand1 = opnd_rs1;
				o_info.alu_operand2 = opnd_imm;
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					// Shifts by immediate carry a shamt and use the R layout.
					o_info.format = fmt_r;
					o_info.alu_operation = alu_for_funct3(funct3, funct7[5]);
					o_info.illegal = (funct3 == 3'b001) ? (funct7 != 7'b0000000)
						: ({funct7[6], funct7[4:0]} != 6'b0);
				end
				else begin
					o_info.format = fmt_i;
					o_info.alu_operation = alu_for_funct3(funct3, 1'b0);
				end
			end
			opc_op: begin
				o_info.format = fmt_r;
				o_info.alu_operand1 = opnd_rs1;
				o_info.alu_operand2 = opnd_rs2;
				o_info.alu_operation = alu_for_funct3(funct3, funct7[5]);
				o_info.illegal = !((funct7 == 7'b0000000)
					|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			default: begin
				o_info.illegal = 1'b1;
			end
		endcase

		// Class of the OP and OP-IMM results follows the ALU operation.
		if (opcode == opc_op || opcode == opc_op_imm) begin
			o_info.shift = o_info.alu_operation inside {alu_sll, alu_srl, alu_sra};
			o_info.compare = o_info.alu_operation inside {alu_slt, alu_sltu};
			o_info.arithmetic = !o_info.shift && !o_info.compare;
		end

		// An undefined encoding reports nothing but the fault.
		if (o_info.illegal) begin
			o_info = '0;
			o_info.illegal = 1'b1;
		end
	end

endmodule

// ==== verilog/rv_fetch_stage.sv ====
/*
 RV32I fetch stage.
 Gives each incoming instruction strobe its program counter and keeps
 only the register fields that the word's format actually carries.
*/
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_fetch_stage
	import rv_pkg::*;
(
	input  logic           i_clock,
	input  logic           i_reset,
	input  logic           i_strobe,
	input  rv_inst_t       i_instruction,
	output rv_fetch_data_t o_data
);

	localparam logic [`RV_XLEN-1:0] pc_step = `RV_XLEN'(4);

	logic [`RV_XLEN-1:0] pc;
	rv_format_t          format;
	logic                has_rs1;
	logic                has_rs2;
	logic                has_rd;

	// The opcode alone tells which register fields exist.
	always_comb begin
		case (i_instruction.r.opcode)
			opc_lui, opc_auipc:               format = fmt_u;
			opc_jal:                          format = fmt_j;
			opc_jalr, opc_load, opc_op_imm:   format = fmt_i;
			opc_branch:                       format = fmt_b;
			opc_store:                        format = fmt_s;
			opc_op:                           format = fmt_r;
			default:                          format = fmt_none;
		endcase
	end

	assign has_rs1 = format inside {fmt_r, fmt_i, fmt_s, fmt_b};
	assign has_rs2 = format inside {fmt_r, fmt_s, fmt_b};
	assign has_rd  = format inside {fmt_r, fmt_i, fmt_u, fmt_j};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= `RV_RESET_PC;
			o_data <= '0;
		end
		else begin
			o_data.strobe <= i_strobe;
			// The word and its fields are held between strobes.
			if (i_strobe) begin
				pc <= pc + pc_step;
				o_data.pc <= pc;
				o_data.instruction <= i_instruction;
				o_data.inst_rs1 <= has_rs1 ? i_instruction.r.rs1 : '0;
				o_data.inst_rs2 <= has_rs2 ? i_instruction.r.rs2 : '0;
				o_data.inst_rd  <= has_rd  ? i_instruction.r.rd  : '0;
			end
		end
	end

endmodule

// ==== verilog/rv_pkg.sv ====
/*
 RV32I front end types.
 Instruction format views, operation encodings and the records that
 travel from fetch to decode and out of the front end.
*/
`include "rv_settings.svh"

package rv_pkg;

	// ========================================================================
	// Instruction word views
	// ========================================================================

	typedef struct packed {
		logic [6:0]              funct7;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [2:0]              funct3;
		logic [`RV_REG_BITS-1:0] rd;
		logic [6:0]              opcode;
	} rv_inst_r_t;

	typedef struct packed {
		logic [11:0]             imm_11_0;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [2:0]              funct3;
		logic [`RV_REG_BITS-1:0] rd;
		logic [6:0]              opcode;
	} rv_inst_i_t;

	typedef struct packed {
		logic [6:0]              imm_11_5;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [2:0]              funct3;
		logic [4:0]              imm_4_0;
		logic [6:0]              opcode;
	} rv_inst_s_t;

	typedef struct packed {
		logic                    imm_12;
		logic [5:0]              imm_10_5;
		logic [`RV_REG_BITS-1:0] rs2;
		logic [`RV_REG_BITS-1:0] rs1;
		logic [2:0]              funct3;
		logic [3:0]              imm_4_1;
		logic                    imm_11;
		logic [6:0]              opcode;
	} rv_inst_b_t;

	typedef struct packed {
		logic [19:0]             imm_31_12;
		logic [`RV_REG_BITS-1:0] rd;
		logic [6:0]              opcode;
	} rv_inst_u_t;

	typedef struct packed {
		logic                    imm_20;
		logic [9:0]              imm_10_1;
		logic                    imm_11;
		logic [7:0]              imm_19_12;
		logic [`RV_REG_BITS-1:0] rd;
		logic [6:0]              opcode;
	} rv_inst_j_t;

	// One 32-bit word, read through the view of whichever format it has.
	typedef union packed {
		rv_inst_r_t r;
		rv_inst_i_t i;
		rv_inst_s_t s;
		rv_inst_b_t b;
		rv_inst_u_t u;
		rv_inst_j_t j;
	} rv_inst_t;

	// Major opcodes of the RV32I base set handled by the front end.
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	// ========================================================================
	// Operation encodings
	// ========================================================================

	typedef enum logic [2:0] {
		fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
	} rv_format_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} rv_alu_op_t;

	typedef enum logic [2:0] {
		opnd_zero, opnd_rs1, opnd_rs2, opnd_pc, opnd_imm
	} rv_operand_t;

	typedef enum logic [1:0] {
		mem_byte, mem_half, mem_word
	} rv_mem_width_t;

	typedef struct packed {
		rv_format_t    format;
		logic          arithmetic;
		logic          shift;
		logic          compare;
		logic          jump;
		logic          jump_conditional;
		rv_alu_op_t    alu_operation;
		rv_operand_t   alu_operand1;
		rv_operand_t   alu_operand2;
		logic          memory_read;
		logic          memory_write;
		rv_mem_width_t memory_width;
		logic          memory_signed;
		logic          illegal;
	} rv_op_info_t;

	// ========================================================================
	// Stage records
	// ========================================================================

	typedef struct packed {
		logic                    strobe;
		logic [`RV_XLEN-1:0]     pc;
		rv_inst_t                instruction;
		logic [`RV_REG_BITS-1:0] inst_rs1;
		logic [`RV_REG_BITS-1:0] inst_rs2;
		logic [`RV_REG_BITS-1:0] inst_rd;
	} rv_fetch_data_t;

	typedef struct packed {
		logic                    strobe;
		logic [`RV_XLEN-1:0]     pc;
		logic [1:0]              have_rs;
		logic [`RV_REG_BITS-1:0] inst_rs1;
		logic [`RV_REG_BITS-1:0] inst_rs2;
		logic [`RV_REG_BITS-1:0] inst_rd;
		logic [`RV_XLEN-1:0]     imm;
		logic                    arithmetic;
		logic                    shift;
		logic                    compare;
		logic                    jump;
		logic                    jump_conditional;
		rv_alu_op_t              alu_operation;
		rv_operand_t             alu_operand1;
		rv_operand_t             alu_operand2;
		logic                    memory_read;
		logic                    memory_write;
		rv_mem_width_t           memory_width;
		logic                    memory_signed;
	} rv_decode_data_t;

endpackage

// ==== verilog/rv_settings.svh ====
/*
 RV32I front end settings.
 Global widths and the reset program counter shared by the package,
 the fetch stage and the decode stage.
*/
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and immediate width.
`define RV_XLEN 32

// Width of a register index field in the instruction word.
`define RV_REG_BITS 5

// Program counter given to the first word fetched after reset.
`define RV_RESET_PC 32'h0000_0000

`endif
